/* Bender.yml */
package:
  name: fetch_unit

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/fetch_pkg.sv
      - src/fetch_axi_reader.sv
      - src/prefetch_buffer.sv
      - src/instr_issue.sv
      - src/fetch_unit.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/fetch_checker.sv
      - test/fetch_tb.sv

/* files.f */
+incdir+src
src/fetch_pkg.sv
src/fetch_axi_reader.sv
src/prefetch_buffer.sv
src/instr_issue.sv
src/fetch_unit.sv
test/fetch_checker.sv
test/fetch_tb.sv

/* src/fetch_axi_reader.sv */
`timescale 1ns/1ps

module fetch_axi_reader (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] fetch_pc,
  input  logic        flush,
  output logic [31:0] araddr,
  output logic        arvalid,
  input  logic        arready,
  input  logic [31:0] rdata,
  input  logic        rvalid,
  output logic        rready,
  output logic [31:0] mem_rdata,
  output logic        mem_ready
);
  import fetch_pkg::*;

  reader_state_t state;
  logic          stale;

  assign arvalid = (state == rd_addr);
  assign rready  = (state == rd_data);

  always_ff @(posedge clk) begin
    if (!rst) begin
      state     <= rd_idle;
      stale     <= 1'b0;
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= 1'b0;
      case (state)
        rd_idle: begin
          state <= rd_addr;
        end
        rd_addr: begin
          if (arready) begin
            state <= rd_data;
          end
          // Address already on the bus belongs to the old stream.
          if (flush) begin
            stale <= 1'b1;
          end
        end
        rd_data: begin
          if (rvalid) begin
            mem_ready <= !(stale || flush);
            stale     <= 1'b0;
            state     <= rd_idle;
          end else if (flush) begin
            stale <= 1'b1;
          end
        end
        default: begin
          state <= rd_idle;
        end
      endcase
    end
  end

  // Fetch address is sampled after the buffer has taken the last word.
  always_ff @(posedge clk) begin
    if (state == rd_idle) begin
      araddr <= fetch_pc;
    end
    if (state == rd_data && rvalid) begin
      mem_rdata <= rdata;
    end
  end

  a_ar_hold: assert property (@(posedge clk) disable iff (!rst)
    arvalid && !arready |=> arvalid && $stable(araddr));

  a_ready_pulse: assert property (@(posedge clk) disable iff (!rst)
    mem_ready |=> !mem_ready);

endmodule

/* src/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// ********************************************************************
// Fetch front end constants.
// ********************************************************************

// Log2 of the prefetch buffer size in halfwords.
`define FETCH_DEPTH_LOG2 3

`define FETCH_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

`endif

/* src/fetch_pkg.sv */
package fetch_pkg;

  // ********************************************************************
  // AXI read master states.
  // ********************************************************************

  // Idle is also the cycle in which a returned word is handed on.
  typedef enum logic [1:0] {
    rd_idle,
    rd_addr,
    rd_data
  } reader_state_t;

  // ********************************************************************
  // Instruction length.
  // ********************************************************************

  // Low two bits of the first halfword both set means a 32-bit instruction.
  typedef enum logic {
    ilen_16,
    ilen_32
  } ilen_t;

endpackage

/* src/fetch_unit.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_unit (
  input  logic        clk,
  input  logic        rst,
  output logic [31:0] araddr,
  output logic        arvalid,
  input  logic        arready,
  input  logic [31:0] rdata,
  input  logic        rvalid,
  output logic        rready,
  output logic        issue_valid,
  output logic [31:0] issue_pc,
  output logic [31:0] issue_instr,
  input  logic        issue_ready,
  input  logic        redirect_valid,
  input  logic [31:0] redirect_pc
);
  import fetch_pkg::*;

  logic [31:0] mem_rdata;
  logic        mem_ready;
  logic [31:0] fetch_pc;
  logic [31:0] pc;
  logic [31:0] npc;
  logic        jump;
  logic [31:0] instr;
  logic        stall;
  ilen_t       ilen;

  fetch_axi_reader u_reader (
    .clk       (clk),
    .rst       (rst),
    .fetch_pc  (fetch_pc),
    .flush     (jump),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rvalid    (rvalid),
    .rready    (rready),
    .mem_rdata (mem_rdata),
    .mem_ready (mem_ready)
  );

  prefetch_buffer u_buffer (
    .clk       (clk),
    .rst       (rst),
    .pc        (pc),
    .npc       (npc),
    .jump      (jump),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .fetch_pc  (fetch_pc),
    .instr     (instr),
    .ilen      (ilen),
    .stall     (stall)
  );

  instr_issue u_issue (
    .clk            (clk),
    .rst            (rst),
    .instr          (instr),
    .ilen           (ilen),
    .stall          (stall),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .issue_ready    (issue_ready),
    .issue_valid    (issue_valid),
    .issue_pc       (issue_pc),
    .issue_instr    (issue_instr),
    .pc             (pc),
    .npc            (npc),
    .jump           (jump)
  );

  // Fetch never runs further ahead of the issue PC than the buffer holds.
  a_fetch_window: assert property (@(posedge clk) disable iff (!rst)
    !jump |-> (fetch_pc - {pc[31:2], 2'b00}) <= (32'd2 << `FETCH_DEPTH_LOG2));

endmodule

/* src/instr_issue.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module instr_issue (
  input  logic              clk,
  input  logic              rst,
  input  logic [31:0]       instr,
  input  fetch_pkg::ilen_t  ilen,
  input  logic              stall,
  input  logic              redirect_valid,
  input  logic [31:0]       redirect_pc,
  input  logic              issue_ready,
  output logic              issue_valid,
  output logic [31:0]       issue_pc,
  output logic [31:0]       issue_instr,
  output logic [31:0]       pc,
  output logic [31:0]       npc,
  output logic              jump
);
  import fetch_pkg::*;

  logic [31:0] seq_pc;
  logic        take;

  assign seq_pc = pc + ((ilen == ilen_32) ? 32'd4 : 32'd2);

  // Redirect wins over the sequential stream.
  assign jump = redirect_valid;
  assign npc  = jump ? redirect_pc : seq_pc;

  assign issue_valid = !stall && !redirect_valid;
  assign take        = issue_valid && issue_ready;

  assign issue_pc    = pc;
  assign issue_instr = issue_valid ? instr : `FETCH_NOP;

  // ********************************************************************
  // Program counter.
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (!rst) begin
      pc <= `FETCH_RESET_PC;
    end else if (jump || take) begin
      pc <= npc;
    end
  end

  // A held instruction must not change under the consumer.
  a_hold_stable: assert property (@(posedge clk) disable iff (!rst)
    issue_valid && !issue_ready |=>
      (issue_valid |-> $stable(issue_instr) && $stable(issue_pc)));

endmodule

/* src/prefetch_buffer.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module prefetch_buffer (
  input  logic              clk,
  input  logic              rst,
  input  logic [31:0]       pc,
  input  logic [31:0]       npc,
  input  logic              jump,
  input  logic              mem_ready,
  input  logic [31:0]       mem_rdata,
  output logic [31:0]       fetch_pc,
  output logic [31:0]       instr,
  output fetch_pkg::ilen_t  ilen,
  output logic              stall
);
  import fetch_pkg::*;

  localparam int AW    = `FETCH_DEPTH_LOG2;
  localparam int DEPTH = 1 << AW;
  localparam logic [31:0] RESET_FPC = `FETCH_RESET_PC & ~32'd3;

  logic [15:0]   buffer [0:DEPTH-1];
  logic [31:0]   fpc;
  logic [31:0]   fpc_next;
  logic [AW-1:0] wid;
  logic [AW-1:0] rid;
  logic [AW-1:0] rid_hi;
  logic          equal;
  logic          full;
  logic          wren;
  logic          wr_buf;
  logic [15:0]   lo_half;
  logic [15:0]   hi_half;
  logic          lo_ok;
  logic          hi_ok;

  // ********************************************************************
  // Pointers and occupancy.
  // ********************************************************************

  assign wid    = fpc[AW:1];
  assign rid    = pc[AW:1];
  assign rid_hi = rid + AW'(1);

  // Same word means empty and same slot in another word means full.
  assign equal = (fpc[31:2] == pc[31:2]);
  assign full  = !equal && (fpc[AW:2] == pc[AW:2]);
  assign wren  = !full;

  // A word arriving while full is dropped and read again later.
  assign wr_buf = mem_ready && wren;

  always_comb begin
    fpc_next = fpc;
    if (wr_buf) begin
      fpc_next = fpc + 32'd4;
    end
    if (jump) begin
      fpc_next = {npc[31:2], 2'b00};
    end
  end

  assign fetch_pc = fpc_next;

  always_ff @(posedge clk) begin
    if (!rst) begin
      fpc <= RESET_FPC;
    end else begin
      fpc <= fpc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_buf) begin
      buffer[wid]         <= mem_rdata[15:0];
      buffer[wid + AW'(1)] <= mem_rdata[31:16];
    end
  end

  // ********************************************************************
  // Instruction assembly at pc.
  // ********************************************************************

  always_comb begin
    lo_half = buffer[rid];
    hi_half = buffer[rid_hi];
    lo_ok   = 1'b1;
    hi_ok   = 1'b1;
    if (equal) begin
      // Nothing is buffered yet so the word comes straight from the bus.
      lo_ok = mem_ready;
      if (pc[1]) begin
        lo_half = mem_rdata[31:16];
        hi_ok   = 1'b0;
      end else begin
        lo_half = mem_rdata[15:0];
        hi_half = mem_rdata[31:16];
        hi_ok   = mem_ready;
      end
    end else if (rid_hi == wid) begin
      // Upper half lives in the word now being fetched.
      hi_half = mem_rdata[15:0];
      hi_ok   = mem_ready;
    end
  end

  assign ilen  = (lo_half[1:0] == 2'b11) ? ilen_32 : ilen_16;
  assign stall = !lo_ok || (ilen == ilen_32 && !hi_ok);

  always_comb begin
    if (stall) begin
      instr = `FETCH_NOP;
    end else if (ilen == ilen_32) begin
      instr = {hi_half, lo_half};
    end else begin
      instr = {16'h0000, lo_half};
    end
  end

  // A word is written only while a free slot lies ahead of the issue PC.
  a_full_no_write: assert property (@(posedge clk) disable iff (!rst)
    wr_buf |-> (fpc - {pc[31:2], 2'b00}) < (32'd2 << AW));

endmodule

/* test/fetch_checker.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_checker (
  input  logic        clk,
  input  logic        rst,
  input  logic        issue_valid,
  input  logic        issue_ready,
  input  logic [31:0] issue_pc,
  input  logic [31:0] issue_instr,
  input  logic        redirect_valid,
  input  logic [31:0] redirect_pc,
  output int          issued,
  output int          pc_errors,
  output int          instr_errors,
  output int          hold_errors
);

  logic [31:0] image [0:255];
  logic [31:0] exp_pc;
  logic        held;
  logic [31:0] held_pc;
  logic [31:0] held_instr;

  task automatic store_word(input int idx, input logic [31:0] w);
    image[idx] = w;
  endtask

  function automatic logic [15:0] half_at(input logic [31:0] addr);
    logic [31:0] word;
    word = image[addr[9:2]];
    return addr[1] ? word[31:16] : word[15:0];
  endfunction

  // Low bits 11 start a 32-bit instruction.
  function automatic logic [31:0] expected_instr(input logic [31:0] addr);
    logic [15:0] lo;
    lo = half_at(addr);
    if (lo[1:0] == 2'b11) begin
      return {half_at(addr + 32'd2), lo};
    end
    return {16'h0000, lo};
  endfunction

  // Outputs settle well before the falling edge.
  always @(negedge clk) begin
    if (!rst) begin
      exp_pc       = `FETCH_RESET_PC;
      held         = 1'b0;
      issued       = 0;
      pc_errors    = 0;
      instr_errors = 0;
      hold_errors  = 0;
    end else begin
      if (held && issue_valid && (issue_pc != held_pc || issue_instr != held_instr)) begin
        hold_errors++;
        $display("FAILED at %0t: held output changed to pc %h instr %h, was pc %h instr %h",
          $time, issue_pc, issue_instr, held_pc, held_instr);
      end
      held = 1'b0;
      if (redirect_valid) begin
        exp_pc = redirect_pc;
      end else if (issue_valid && issue_ready) begin
        if (issue_pc != exp_pc) begin
          pc_errors++;
          $display("FAILED at %0t: issue_pc %h, expected %h", $time, issue_pc, exp_pc);
        end
        if (issue_instr != expected_instr(exp_pc)) begin
          instr_errors++;
          $display("FAILED at %0t: issue_instr %h at pc %h, expected %h",
            $time, issue_instr, exp_pc, expected_instr(exp_pc));
        end
        exp_pc = exp_pc + ((half_at(exp_pc) & 16'h3) == 16'h3 ? 32'd4 : 32'd2);
        issued++;
      end else if (issue_valid) begin
        held       = 1'b1;
        held_pc    = issue_pc;
        held_instr = issue_instr;
      end
    end
  end

endmodule

/* test/fetch_tb.sv */
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_tb;

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 5;
  localparam int NUM_INSTR       = 2000;
  localparam int WATCHDOG_CYCLES = NUM_INSTR * 20 + 1000;
  localparam logic [31:0] SEED   = 32'd81383;

  logic        clk;
  logic        rst;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic        rvalid;
  logic        rready;
  logic        issue_valid;
  logic [31:0] issue_pc;
  logic [31:0] issue_instr;
  logic        issue_ready;
  logic        redirect_valid;
  logic [31:0] redirect_pc;

  int          issued;
  int          pc_errors;
  int          instr_errors;
  int          hold_errors;
  int          reset_count;

  logic [31:0] lfsr;
  logic [31:0] image [0:255];
  logic [31:0] pend_addr;
  logic        pending;
  logic [1:0]  ar_wait;
  logic [1:0]  r_wait;

  fetch_unit dut (
    .clk            (clk),
    .rst            (rst),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .arready        (arready),
    .rdata          (rdata),
    .rvalid         (rvalid),
    .rready         (rready),
    .issue_valid    (issue_valid),
    .issue_pc       (issue_pc),
    .issue_instr    (issue_instr),
    .issue_ready    (issue_ready),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  fetch_checker chk (
    .clk            (clk),
    .rst            (rst),
    .issue_valid    (issue_valid),
    .issue_ready    (issue_ready),
    .issue_pc       (issue_pc),
    .issue_instr    (issue_instr),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .issued         (issued),
    .pc_errors      (pc_errors),
    .instr_errors   (instr_errors),
    .hold_errors    (hold_errors)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ********************************************************************
  // Random source.
  // ********************************************************************

  // Taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // ********************************************************************
  // AXI memory model and consumer.
  // ********************************************************************

  // One read at a time with 0 to 3 wait cycles on AR and again on R.
  task automatic drive_memory();
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = 32'h0;
    if (!pending) begin
      if (arvalid) begin
        if (ar_wait == 2'd0) begin
          arready   = 1'b1;
          pend_addr = araddr;
          pending   = 1'b1;
          r_wait    = 2'(rand_bits(2));
          ar_wait   = 2'(rand_bits(2));
        end else begin
          ar_wait = ar_wait - 2'd1;
        end
      end
    end else if (rready) begin
      if (r_wait == 2'd0) begin
        rvalid  = 1'b1;
        rdata   = image[pend_addr[9:2]];
        pending = 1'b0;
      end else begin
        r_wait = r_wait - 2'd1;
      end
    end
  endtask

  task automatic drive_consumer();
    if (redirect_valid) begin
      redirect_valid = 1'b0;
    end else if (rand_bits(5) == 32'd0) begin
      redirect_valid = 1'b1;
      redirect_pc    = rand_bits(9) << 1;
    end
    issue_ready = (rand_bits(2) != 32'd0);
  endtask

  always begin
    @(posedge clk);
    #1;
    if (!rst) begin
      reset_count++;
      if (reset_count == RESET_CYCLES) begin
        rst = 1'b1;
      end
    end else begin
      drive_memory();
      drive_consumer();
    end
  end

  initial begin
    int          i;
    logic [31:0] w;
    clk            = 1'b0;
    rst            = 1'b0;
    arready        = 1'b0;
    rdata          = 32'h0;
    rvalid         = 1'b0;
    issue_ready    = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = 32'h0;
    reset_count    = 0;
    pending        = 1'b0;
    pend_addr      = 32'h0;
    r_wait         = 2'd0;
    lfsr           = SEED;
    for (i = 0; i < 256; i++) begin
      w        = rand_bits(32);
      image[i] = w;
      chk.store_word(i, w);
    end
    ar_wait = 2'(rand_bits(2));
    while (issued < NUM_INSTR) begin
      @(posedge clk);
    end
    @(posedge clk);
    $display("Issued %0d, pc errors %0d, instr errors %0d, hold errors %0d",
      issued, pc_errors, instr_errors, hold_errors);
    if (pc_errors + instr_errors + hold_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles with only %0d of %0d instructions issued",
      WATCHDOG_CYCLES, issued, NUM_INSTR);
    $display("Result: FAILED");
    $finish;
  end

endmodule
